// ==== Makefile ====
SRC = src/fpst_pkg.sv src/dispatch_queue.sv src/operand_capture.sv \
      src/issue_station.sv src/muladd_unit.sv src/fpst_top.sv

.PHONY: all lint clean

all:
	verilator --binary -f tb.f --top-module tb_fpst -o sim_fpst
	./obj_dir/sim_fpst | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module fpst_top $(SRC)

clean:
	rm -rf obj_dir sim.log

// ==== src/dispatch_queue.sv ====
module dispatch_queue #(
	parameter int QDEPTH = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                push_i,
	input  fpst_pkg::rob_ndx_t  push_id_i,
	input  fpst_pkg::fop_t      push_op_i,
	input  fpst_pkg::pregno_t   push_rs1_i,
	input  fpst_pkg::pregno_t   push_rs2_i,
	input  fpst_pkg::pregno_t   push_rs3_i,
	input  fpst_pkg::pregno_t   push_rd_i,
	output logic                full_o,
	input  logic                take_i,
	output logic                valid_o,
	output fpst_pkg::rob_ndx_t  head_id_o,
	output fpst_pkg::fop_t      head_op_o,
	output fpst_pkg::pregno_t   head_rs1_o,
	output fpst_pkg::pregno_t   head_rs2_o,
	output fpst_pkg::pregno_t   head_rs3_o,
	output fpst_pkg::pregno_t   head_rd_o
);

	// Pointer width, the depth is a power of two so pointers wrap on their own
	localparam int AW = $clog2(QDEPTH);
	localparam logic [AW:0] CNT_FULL = (AW+1)'(QDEPTH);

	// One storage array per field of the decoded operation
	fpst_pkg::rob_ndx_t mem_id  [QDEPTH];
	fpst_pkg::fop_t     mem_op  [QDEPTH];
	fpst_pkg::pregno_t  mem_rs1 [QDEPTH];
	fpst_pkg::pregno_t  mem_rs2 [QDEPTH];
	fpst_pkg::pregno_t  mem_rs3 [QDEPTH];
	fpst_pkg::pregno_t  mem_rd  [QDEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_take;

	assign full_o  = (count == CNT_FULL);
	assign valid_o = (count != '0);

	// A push while full is silently dropped
	assign do_push = push_i && !full_o;
	assign do_take = take_i && valid_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_take)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and take leave the count unchanged
			case ({do_push, do_take})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem_id[wr_ptr]  <= push_id_i;
			mem_op[wr_ptr]  <= push_op_i;
			mem_rs1[wr_ptr] <= push_rs1_i;
			mem_rs2[wr_ptr] <= push_rs2_i;
			mem_rs3[wr_ptr] <= push_rs3_i;
			mem_rd[wr_ptr]  <= push_rd_i;
		end
	end

	// The head is read straight out of storage, so a push shows up next cycle
	assign head_id_o  = mem_id[rd_ptr];
	assign head_op_o  = mem_op[rd_ptr];
	assign head_rs1_o = mem_rs1[rd_ptr];
	assign head_rs2_o = mem_rs2[rd_ptr];
	assign head_rs3_o = mem_rs3[rd_ptr];
	assign head_rd_o  = mem_rd[rd_ptr];

endmodule

// ==== src/fpst_pkg.sv ====
package fpst_pkg;

	// ========================================================================
	// Field widths of the multiply-add reservation path
	// ========================================================================

	// Operand values are plain integers that wrap modulo 2^32
	localparam int VALUE_W = 32;
	// Physical register numbers address a 64-entry file
	localparam int PREG_W = 6;
	// Reorder-buffer ids track up to 32 operations in flight
	localparam int ROB_W = 5;

	// ========================================================================
	// Shared types
	// ========================================================================

	typedef logic [VALUE_W-1:0] value_t;
	typedef logic [PREG_W-1:0] pregno_t;
	typedef logic [ROB_W-1:0] rob_ndx_t;

	// Opcodes of the unit
	// A and B are always the first two sources, C is only read by MADD
	typedef enum logic [1:0] {
		FOP_ADD  = 2'd0,
		FOP_MUL  = 2'd1,
		FOP_MADD = 2'd2,
		FOP_CPY  = 2'd3
	} fop_t;

	// ========================================================================
	// Constants
	// ========================================================================

	localparam value_t value_zero = '0;

	// Register 0 is hard-wired to zero and is never broadcast
	localparam pregno_t PREG_ZERO = '0;

endpackage

// ==== src/fpst_top.sv ====
module fpst_top #(
	parameter int NPORTS = 4,
	parameter int QDEPTH = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            push_i,
	input  fpst_pkg::rob_ndx_t              push_id_i,
	input  fpst_pkg::fop_t                  push_op_i,
	input  fpst_pkg::pregno_t               push_rs1_i,
	input  fpst_pkg::pregno_t               push_rs2_i,
	input  fpst_pkg::pregno_t               push_rs3_i,
	input  fpst_pkg::pregno_t               push_rd_i,
	output logic                            full_o,
	// Register-file broadcast ports driven from outside
	input  fpst_pkg::pregno_t [NPORTS-1:0]  rf_prn_i,
	input  logic [NPORTS-1:0]               rf_prnv_i,
	input  fpst_pkg::value_t [NPORTS-1:0]   rf_val_i,
	output logic                            res_valid_o,
	output fpst_pkg::rob_ndx_t              res_id_o,
	output fpst_pkg::pregno_t               res_rd_o,
	output fpst_pkg::value_t                res_val_o
);

	// Queue head
	logic               q_valid;
	logic               q_take;
	fpst_pkg::rob_ndx_t q_id;
	fpst_pkg::fop_t     q_op;
	fpst_pkg::pregno_t  q_rs1;
	fpst_pkg::pregno_t  q_rs2;
	fpst_pkg::pregno_t  q_rs3;
	fpst_pkg::pregno_t  q_rd;

	// Broadcast bus seen by the station
	fpst_pkg::pregno_t [NPORTS:0] bc_prn;
	logic [NPORTS:0]              bc_prnv;
	fpst_pkg::value_t [NPORTS:0]  bc_val;

	// Station issue
	logic               iss;
	fpst_pkg::rob_ndx_t iss_id;
	fpst_pkg::fop_t     iss_op;
	fpst_pkg::pregno_t  iss_rd;
	fpst_pkg::value_t   iss_a;
	fpst_pkg::value_t   iss_b;
	fpst_pkg::value_t   iss_c;

	// The unit result rides on the top port so dependents can wake on it
	assign bc_prn  = {res_rd_o, rf_prn_i};
	assign bc_prnv = {res_valid_o, rf_prnv_i};
	assign bc_val  = {res_val_o, rf_val_i};

	dispatch_queue #(
		.QDEPTH (QDEPTH)
	) u_queue (
		.clk        (clk),
		.rst        (rst),
		.push_i     (push_i),
		.push_id_i  (push_id_i),
		.push_op_i  (push_op_i),
		.push_rs1_i (push_rs1_i),
		.push_rs2_i (push_rs2_i),
		.push_rs3_i (push_rs3_i),
		.push_rd_i  (push_rd_i),
		.full_o     (full_o),
		.take_i     (q_take),
		.valid_o    (q_valid),
		.head_id_o  (q_id),
		.head_op_o  (q_op),
		.head_rs1_o (q_rs1),
		.head_rs2_o (q_rs2),
		.head_rs3_o (q_rs3),
		.head_rd_o  (q_rd)
	);

	issue_station #(
		.NPORTS (NPORTS)
	) u_station (
		.clk       (clk),
		.rst       (rst),
		.q_valid_i (q_valid),
		.q_take_o  (q_take),
		.q_id_i    (q_id),
		.q_op_i    (q_op),
		.q_rs1_i   (q_rs1),
		.q_rs2_i   (q_rs2),
		.q_rs3_i   (q_rs3),
		.q_rd_i    (q_rd),
		.bc_prn_i  (bc_prn),
		.bc_prnv_i (bc_prnv),
		.bc_val_i  (bc_val),
		.iss_o     (iss),
		.iss_id_o  (iss_id),
		.iss_op_o  (iss_op),
		.iss_rd_o  (iss_rd),
		.iss_a_o   (iss_a),
		.iss_b_o   (iss_b),
		.iss_c_o   (iss_c)
	);

	muladd_unit u_unit (
		.clk         (clk),
		.rst         (rst),
		.iss_i       (iss),
		.id_i        (iss_id),
		.op_i        (iss_op),
		.rd_i        (iss_rd),
		.a_i         (iss_a),
		.b_i         (iss_b),
		.c_i         (iss_c),
		.res_valid_o (res_valid_o),
		.res_id_o    (res_id_o),
		.res_rd_o    (res_rd_o),
		.res_val_o   (res_val_o)
	);

endmodule

// ==== src/issue_station.sv ====
module issue_station #(
	parameter int NPORTS = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	// Head of the dispatch queue
	input  logic                           q_valid_i,
	output logic                           q_take_o,
	input  fpst_pkg::rob_ndx_t             q_id_i,
	input  fpst_pkg::fop_t                 q_op_i,
	input  fpst_pkg::pregno_t              q_rs1_i,
	input  fpst_pkg::pregno_t              q_rs2_i,
	input  fpst_pkg::pregno_t              q_rs3_i,
	input  fpst_pkg::pregno_t              q_rd_i,
	// Result broadcast, external ports plus the looped-back unit result
	input  fpst_pkg::pregno_t [NPORTS:0]   bc_prn_i,
	input  logic [NPORTS:0]                bc_prnv_i,
	input  fpst_pkg::value_t [NPORTS:0]    bc_val_i,
	// Issue towards the multiply-add unit
	output logic                           iss_o,
	output fpst_pkg::rob_ndx_t             iss_id_o,
	output fpst_pkg::fop_t                 iss_op_o,
	output fpst_pkg::pregno_t              iss_rd_o,
	output fpst_pkg::value_t               iss_a_o,
	output fpst_pkg::value_t               iss_b_o,
	output fpst_pkg::value_t               iss_c_o
);

	// ========================================================================
	// Station state
	// ========================================================================

	logic               busy;
	fpst_pkg::rob_ndx_t id_q;
	fpst_pkg::fop_t     op_q;
	fpst_pkg::pregno_t  rd_q;
	logic               load;
	fpst_pkg::pregno_t  src_b;
	fpst_pkg::pregno_t  src_c;
	logic               a_valid;
	logic               b_valid;
	logic               c_valid;

	// The head is taken whenever the station is empty
	// The queue pops on the same edge that loads the station
	assign q_take_o = !busy && q_valid_i;
	assign load     = q_take_o;

	// Sources that the opcode does not read are parked on register 0
	// CPY only reads A, ADD and MUL never read C
	assign src_b = (q_op_i == fpst_pkg::FOP_CPY) ? fpst_pkg::PREG_ZERO : q_rs2_i;
	assign src_c = (q_op_i == fpst_pkg::FOP_MADD) ? q_rs3_i : fpst_pkg::PREG_ZERO;

	// ========================================================================
	// Operand capture, one per source
	// ========================================================================

	operand_capture #(
		.NPORTS (NPORTS)
	) u_src_a (
		.clk     (clk),
		.rst     (rst),
		.load_i  (load),
		.preg_i  (q_rs1_i),
		.prn_i   (bc_prn_i),
		.prnv_i  (bc_prnv_i),
		.val_i   (bc_val_i),
		.valid_o (a_valid),
		.val_o   (iss_a_o)
	);

	operand_capture #(
		.NPORTS (NPORTS)
	) u_src_b (
		.clk     (clk),
		.rst     (rst),
		.load_i  (load),
		.preg_i  (src_b),
		.prn_i   (bc_prn_i),
		.prnv_i  (bc_prnv_i),
		.val_i   (bc_val_i),
		.valid_o (b_valid),
		.val_o   (iss_b_o)
	);

	operand_capture #(
		.NPORTS (NPORTS)
	) u_src_c (
		.clk     (clk),
		.rst     (rst),
		.load_i  (load),
		.preg_i  (src_c),
		.prn_i   (bc_prn_i),
		.prnv_i  (bc_prnv_i),
		.val_i   (bc_val_i),
		.valid_o (c_valid),
		.val_o   (iss_c_o)
	);

	// Fire on the first cycle that all three sources are ready
	assign iss_o = busy && a_valid && b_valid && c_valid;

	// Loading needs an idle station, so load and fire never coincide
	always_ff @(posedge clk) begin
		if (rst)
			busy <= 1'b0;
		else if (load)
			busy <= 1'b1;
		else if (iss_o)
			busy <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load) begin
			id_q <= q_id_i;
			op_q <= q_op_i;
			rd_q <= q_rd_i;
		end
	end

	assign iss_id_o = id_q;
	assign iss_op_o = op_q;
	assign iss_rd_o = rd_q;

endmodule

// ==== src/muladd_unit.sv ====
module muladd_unit (
	input  logic               clk,
	input  logic               rst,
	input  logic               iss_i,
	input  fpst_pkg::rob_ndx_t id_i,
	input  fpst_pkg::fop_t     op_i,
	input  fpst_pkg::pregno_t  rd_i,
	input  fpst_pkg::value_t   a_i,
	input  fpst_pkg::value_t   b_i,
	input  fpst_pkg::value_t   c_i,
	output logic               res_valid_o,
	output fpst_pkg::rob_ndx_t res_id_o,
	output fpst_pkg::pregno_t  res_rd_o,
	output fpst_pkg::value_t   res_val_o
);

	// ========================================================================
	// Stage 1, product and addend
	// ========================================================================

	logic               s1_valid;
	fpst_pkg::rob_ndx_t s1_id;
	fpst_pkg::fop_t     s1_op;
	fpst_pkg::pregno_t  s1_rd;
	fpst_pkg::value_t   s1_a;
	fpst_pkg::value_t   s1_prod;
	fpst_pkg::value_t   s1_addend;
	fpst_pkg::value_t   s2_sum;

	always_ff @(posedge clk) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= iss_i;
	end

	// Only the low 32 bits of the product are kept
	// ADD takes B as its addend, MADD takes C
	always_ff @(posedge clk) begin
		if (iss_i) begin
			s1_id     <= id_i;
			s1_op     <= op_i;
			s1_rd     <= rd_i;
			s1_a      <= a_i;
			s1_prod   <= a_i * b_i;
			s1_addend <= (op_i == fpst_pkg::FOP_MADD) ? c_i : b_i;
		end
	end

	// ========================================================================
	// Stage 2, select and add
	// ========================================================================

	always_comb begin
		case (s1_op)
			fpst_pkg::FOP_ADD:  s2_sum = s1_a + s1_addend;
			fpst_pkg::FOP_MUL:  s2_sum = s1_prod;
			fpst_pkg::FOP_MADD: s2_sum = s1_prod + s1_addend;
			default:            s2_sum = s1_a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			res_valid_o <= 1'b0;
		else
			res_valid_o <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			res_id_o  <= s1_id;
			res_rd_o  <= s1_rd;
			res_val_o <= s2_sum;
		end
	end

endmodule

// ==== src/operand_capture.sv ====
module operand_capture #(
	parameter int NPORTS = 4
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           load_i,
	input  fpst_pkg::pregno_t              preg_i,
	input  fpst_pkg::pregno_t [NPORTS:0]   prn_i,
	input  logic [NPORTS:0]                prnv_i,
	input  fpst_pkg::value_t [NPORTS:0]    val_i,
	output logic                           valid_o,
	output fpst_pkg::value_t               val_o
);

	fpst_pkg::pregno_t preg_q;
	fpst_pkg::value_t  val_q;
	logic              valid_q;
	logic              hit;
	fpst_pkg::value_t  hit_val;

	// Compare the awaited register against every broadcast port
	// Scanning downwards lets the lowest matching port win
	always_comb begin
		hit     = 1'b0;
		hit_val = fpst_pkg::value_zero;
		for (int i = NPORTS; i >= 0; i--) begin
			if (prnv_i[i] && (prn_i[i] == preg_q)) begin
				hit     = 1'b1;
				hit_val = val_i[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= 1'b0;
		else if (load_i)
			// Register 0 needs no broadcast and is ready straight away
			valid_q <= (preg_i == fpst_pkg::PREG_ZERO);
		else if (!valid_q && hit)
			valid_q <= 1'b1;
	end

	// Once captured the value stays put until the next load
	always_ff @(posedge clk) begin
		if (load_i) begin
			preg_q <= preg_i;
			val_q  <= fpst_pkg::value_zero;
		end else if (!valid_q && hit) begin
			val_q <= hit_val;
		end
	end

	assign valid_o = valid_q;
	assign val_o   = val_q;

endmodule

// ==== tb.f ====
src/fpst_pkg.sv
src/dispatch_queue.sv
src/operand_capture.sv
src/issue_station.sv
src/muladd_unit.sv
src/fpst_top.sv
testbench/tb_fpst.sv

// ==== testbench/tb_fpst.sv ====
module tb_fpst;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NP = 4;
	localparam int QD = 4;
	localparam int TIMEOUT_CYCLES = 200 * 25;

	logic                        clk;
	logic                        rst;
	logic                        push;
	fpst_pkg::rob_ndx_t          push_id;
	fpst_pkg::fop_t              push_op;
	fpst_pkg::pregno_t           push_rs1;
	fpst_pkg::pregno_t           push_rs2;
	fpst_pkg::pregno_t           push_rs3;
	fpst_pkg::pregno_t           push_rd;
	logic                        full;
	fpst_pkg::pregno_t [NP-1:0]  rf_prn;
	logic [NP-1:0]               rf_prnv;
	fpst_pkg::value_t [NP-1:0]   rf_val_bc;
	logic                        res_valid;
	fpst_pkg::rob_ndx_t          res_id;
	fpst_pkg::pregno_t           res_rd;
	fpst_pkg::value_t            res_val;

	// Register model, the rotation list holds registers the model broadcasts
	fpst_pkg::value_t  rf_val [64];
	fpst_pkg::pregno_t bc_list [$];
	bit                pend_wait [64];
	int                rel_at [64];
	// Expectations in dispatch order
	fpst_pkg::value_t   exp_val_q [$];
	fpst_pkg::rob_ndx_t exp_id_q [$];
	fpst_pkg::pregno_t  exp_rd_q [$];

	logic [31:0]       rng_state = 32'd53607;
	int                errors = 0;
	int                cycles = 0;
	int                n_results = 0;
	int                n_ops = 0;
	int                rot = 0;
	int                next_dest = 32;
	int                next_pend = 16;
	fpst_pkg::pregno_t prev_rd = fpst_pkg::PREG_ZERO;

	fpst_top #(
		.NPORTS (NP),
		.QDEPTH (QD)
	) i_dut (
		.clk         (clk),
		.rst         (rst),
		.push_i      (push),
		.push_id_i   (push_id),
		.push_op_i   (push_op),
		.push_rs1_i  (push_rs1),
		.push_rs2_i  (push_rs2),
		.push_rs3_i  (push_rs3),
		.push_rd_i   (push_rd),
		.full_o      (full),
		.rf_prn_i    (rf_prn),
		.rf_prnv_i   (rf_prnv),
		.rf_val_i    (rf_val_bc),
		.res_valid_o (res_valid),
		.res_id_o    (res_id),
		.res_rd_o    (res_rd),
		.res_val_o   (res_val)
	);

	always #2 clk = ~clk;

	// ========================================================================
	// Reference model and helpers
	// ========================================================================

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Opcode rule, all arithmetic wraps at 32 bits
	function automatic fpst_pkg::value_t fpst_expect(fpst_pkg::fop_t op, fpst_pkg::value_t a,
			fpst_pkg::value_t b, fpst_pkg::value_t c);
		case (op)
			fpst_pkg::FOP_ADD:  return a + b;
			fpst_pkg::FOP_MUL:  return a * b;
			fpst_pkg::FOP_MADD: return a * b + c;
			default:            return a;
		endcase
	endfunction

	task automatic drop_from_rotation(input fpst_pkg::pregno_t r);
		for (int i = bc_list.size() - 1; i >= 0; i--)
			if (bc_list[i] == r)
				bc_list.delete(i);
	endtask

	task automatic check_value(input fpst_pkg::value_t got, input fpst_pkg::value_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: result value %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_id(input fpst_pkg::rob_ndx_t got, input fpst_pkg::rob_ndx_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: result id %0d, expected %0d", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_preg(input fpst_pkg::pregno_t got, input fpst_pkg::pregno_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: result register %0d, expected %0d", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic drain();
		while (exp_val_q.size() != 0)
			@(posedge clk);
		#1;
		// Once its result has gone by, the newest destination can only come
		// from the register file, so it joins the rotation
		if (prev_rd != fpst_pkg::PREG_ZERO) begin
			drop_from_rotation(prev_rd);
			bc_list.push_back(prev_rd);
		end
	endtask

	// Pending registers get a fresh value and are broadcast some cycles later
	// The pool is reused only after every older operation has completed
	task automatic alloc_pending(output fpst_pkg::pregno_t r);
		if (next_pend == 16 && n_ops != 0)
			drain();
		r = fpst_pkg::pregno_t'(next_pend);
		next_pend = (next_pend == 31) ? 16 : next_pend + 1;
		drop_from_rotation(r);
		rf_val[r] = xorshift();
		rel_at[r] = cycles + 3 + int'(xorshift() % 20);
		pend_wait[r] = 1'b1;
	endtask

	// Every operation gets a fresh destination from registers 32 to 63
	task automatic issue_op(input fpst_pkg::fop_t op, input fpst_pkg::pregno_t s1,
			input fpst_pkg::pregno_t s2, input fpst_pkg::pregno_t s3);
		fpst_pkg::value_t  expv;
		fpst_pkg::pregno_t rd;
		expv = fpst_expect(op, rf_val[s1], rf_val[s2], rf_val[s3]);
		rd = fpst_pkg::pregno_t'(next_dest);
		next_dest = (next_dest == 63) ? 32 : next_dest + 1;
		drop_from_rotation(rd);
		rf_val[rd] = expv;
		while (full) begin
			@(posedge clk);
			#1;
		end
		push     = 1'b1;
		push_id  = fpst_pkg::rob_ndx_t'(n_ops);
		push_op  = op;
		push_rs1 = s1;
		push_rs2 = s2;
		push_rs3 = s3;
		push_rd  = rd;
		exp_val_q.push_back(expv);
		exp_id_q.push_back(fpst_pkg::rob_ndx_t'(n_ops));
		exp_rd_q.push_back(rd);
		n_ops++;
		prev_rd = rd;
		@(posedge clk);
		#1;
		push = 1'b0;
	endtask

	// ========================================================================
	// Register-file broadcast, checker and timeout
	// ========================================================================

	always begin
		@(posedge clk);
		#1;
		for (int r = 16; r < 32; r++) begin
			if (pend_wait[r] && cycles >= rel_at[r]) begin
				pend_wait[r] = 1'b0;
				bc_list.push_back(fpst_pkg::pregno_t'(r));
			end
		end
		// Idle ports carry junk so that only the valid bit counts
		for (int p = 0; p < NP; p++) begin
			rf_prnv[p]   = 1'b0;
			rf_prn[p]    = fpst_pkg::pregno_t'(xorshift());
			rf_val_bc[p] = xorshift();
			if (bc_list.size() > 0 && xorshift() % 4 != 0) begin
				rf_prnv[p]   = 1'b1;
				rf_prn[p]    = bc_list[(rot + p) % bc_list.size()];
				rf_val_bc[p] = rf_val[rf_prn[p]];
			end
		end
		rot += NP;
	end

	// Results are sampled half a cycle after the edge that produced them
	// A dependent already in flight sees this value only on the looped-back port
	always @(negedge clk) begin
		if (!rst && res_valid) begin
			if (exp_val_q.size() == 0) begin
				$display("Error at %0t: a result came out with no operation outstanding", $time);
				errors++;
			end else begin
				check_value(res_val, exp_val_q.pop_front());
				check_id(res_id, exp_id_q.pop_front());
				check_preg(res_rd, exp_rd_q.pop_front());
			end
			n_results++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("The run timed out after %0d cycles with %0d of %0d results seen",
				cycles, n_results, n_ops);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		fpst_pkg::pregno_t src [3];
		fpst_pkg::pregno_t held;
		fpst_pkg::fop_t    op;
		logic [31:0]       r;
		bit                pend_used;
		int                n_extra;
		int                n_random;

		clk       = 1'b0;
		rst       = 1'b1;
		push      = 1'b0;
		push_id   = '0;
		push_op   = fpst_pkg::FOP_ADD;
		push_rs1  = '0;
		push_rs2  = '0;
		push_rs3  = '0;
		push_rd   = '0;
		rf_prn    = '0;
		rf_prnv   = '0;
		rf_val_bc = '0;
		// Registers 1 to 14 are known, 15 is never broadcast
		for (int i = 0; i < 64; i++) begin
			rf_val[i]    = (i == 0) ? fpst_pkg::value_zero : xorshift();
			pend_wait[i] = 1'b0;
			rel_at[i]    = 0;
		end
		for (int i = 1; i < 15; i++)
			bc_list.push_back(fpst_pkg::pregno_t'(i));
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// Nothing pushed yet, so the outputs must stay quiet
		repeat (6) begin
			@(posedge clk);
			#1;
			check_flag(res_valid, 1'b0, "res_valid_o after reset");
			check_flag(full, 1'b0, "full_o after reset");
		end

		// Withhold one operand and fill the queue behind it
		alloc_pending(held);
		pend_wait[held] = 1'b0;
		issue_op(fpst_pkg::FOP_MADD, held, 3, 0);
		issue_op(fpst_pkg::FOP_ADD, prev_rd, 5, 15);
		n_extra = 1;
		while (!full && n_extra < 10) begin
			issue_op(fpst_pkg::FOP_CPY, fpst_pkg::pregno_t'(1 + n_extra), 15, 15);
			n_extra++;
		end
		if (n_extra != QD) begin
			$display("Error at %0t: full_o rose after %0d pushes behind the station, not %0d",
				$time, n_extra, QD);
			errors++;
		end
		repeat (10) @(posedge clk);
		#1;
		if (n_results != 0) begin
			$display("Error at %0t: results appeared before the withheld operand", $time);
			errors++;
		end
		bc_list.push_back(held);
		drain();

		// Random mix of opcodes and source kinds
		n_random = 200 - n_ops;
		for (int k = 0; k < n_random; k++) begin
			r = xorshift();
			op = fpst_pkg::fop_t'(r[1:0]);
			pend_used = 1'b0;
			for (int s = 0; s < 3; s++) begin
				r = xorshift();
				case (r[2:0])
					3'd0: src[s] = fpst_pkg::PREG_ZERO;
					3'd5, 3'd6: src[s] = prev_rd;
					3'd7: begin
						if (!pend_used) begin
							alloc_pending(src[s]);
							pend_used = 1'b1;
						end else begin
							src[s] = fpst_pkg::pregno_t'(1 + r[7:4] % 14);
						end
					end
					default: src[s] = fpst_pkg::pregno_t'(1 + r[7:4] % 14);
				endcase
			end
			// Unused sources name a register that is never broadcast
			if (op != fpst_pkg::FOP_MADD)
				src[2] = 15;
			if (op == fpst_pkg::FOP_CPY)
				src[1] = 15;
			issue_op(op, src[0], src[1], src[2]);
			if (xorshift() % 4 == 0) begin
				@(posedge clk);
				#1;
			end
		end
		drain();
		repeat (5) @(posedge clk);

		if (n_results != n_ops) begin
			$display("Error: %0d operations pushed but %0d results seen", n_ops, n_results);
			errors++;
		end
		$display("Checks done with %0d errors over %0d operations", errors, n_ops);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
